// File: iso_frame_pkg.sv
package iso_frame_pkg;

    // one byte of a tag response
    typedef logic [7:0] byte_t;

    // bits still to send in a byte
    // also the first byte's length minus one
    typedef logic [2:0] bit_count_t;

    // CRC_A register width
    typedef logic [15:0] crc_t;

    // CRC_A start value
    localparam crc_t CRC_A_PRESET = 16'h6363;

    // x^16 + x^12 + x^5 + 1, bit reversed for lsb first shifting
    localparam crc_t CRC_A_POLY = 16'h8408;

    // transmit controller states
    typedef enum logic [2:0] {
        // waiting for a frame from the source
        CTRL_IDLE,
        // passing source bytes through
        CTRL_DATA,
        // crc low byte on the serialiser input
        CTRL_CRC_LO,
        // crc high byte on the serialiser input
        CTRL_CRC_HI,
        // no more data, waiting for the framer to close the frame
        CTRL_DRAIN
    } ctrl_state_t;

endpackage

// File: tx_signal_pkg.sv
package tx_signal_pkg;

    // one elementary time unit, 128 carrier clocks
    localparam int ETU_CYCLES = 128;

    // manchester half bit
    localparam int HALF_ETU_CYCLES = 64;

    // fc/16 subcarrier, 8 clocks high then 8 low
    localparam int SUBCARRIER_HALF = 8;

    // position inside the current etu
    typedef logic [6:0] etu_count_t;

    // encoder phases
    typedef enum logic {
        // nothing latched, watching enc_active
        ENC_IDLE,
        // counting out an etu for the latched symbol
        ENC_BIT
    } enc_phase_t;

endpackage

// File: crc_a.sv
`timescale 1ns/1ps

module crc_a (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 crc_init,
    input  logic                 crc_byte_en,
    input  iso_frame_pkg::byte_t crc_byte,
    output iso_frame_pkg::crc_t  crc_value
);

    import iso_frame_pkg::*;

    crc_t crc_next;

    // whole byte per clock, lsb first
    always_comb begin
        crc_next = crc_value ^ {8'h00, crc_byte};
        for (int i = 0; i < 8; i++) begin
            if (crc_next[0]) begin
                crc_next = (crc_next >> 1) ^ CRC_A_POLY;
            end else begin
                crc_next = crc_next >> 1;
            end
        end
    end

    // no final xor for CRC_A
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_value <= CRC_A_PRESET;
        end else if (crc_init) begin
            crc_value <= CRC_A_PRESET;
        end else if (crc_byte_en) begin
            crc_value <= crc_next;
        end
    end

endmodule

// File: serialiser.sv
`timescale 1ns/1ps

module serialiser (
    input  logic                      clk,
    input  logic                      rst_n,
    // byte side
    input  iso_frame_pkg::byte_t      ser_data,
    input  logic                      ser_data_valid,
    input  iso_frame_pkg::bit_count_t src_bits,
    output logic                      ser_byte_req,
    // bit side
    input  logic                      ser_bit_req,
    output logic                      ser_bit,
    output logic                      ser_bit_valid
);

    import iso_frame_pkg::*;

    byte_t      cached_data;
    bit_count_t bit_count;
    logic       idle;

    // set between a byte request and the next bit request
    logic       cache_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ser_byte_req <= 1'b0;
            idle         <= 1'b1;
            bit_count    <= '0;
            cache_data   <= 1'b0;
        end else begin
            ser_byte_req <= 1'b0;

            if (idle) begin
                // first byte of a frame
                if (ser_data_valid) begin
                    idle       <= 1'b0;
                    bit_count  <= src_bits;
                    cache_data <= 1'b0;
                end
            end else if (ser_bit_req) begin
                // new byte, if any, is now fixed
                cache_data <= 1'b0;

                if (bit_count == '0) begin
                    // last bit gone, need another byte
                    ser_byte_req <= 1'b1;
                    bit_count    <= 3'd7;
                    cache_data   <= 1'b1;
                end else begin
                    bit_count <= bit_count - 1'b1;
                end
            end else if (cache_data && !ser_data_valid) begin
                // upstream ran dry
                idle       <= 1'b1;
                cache_data <= 1'b0;
            end
        end
    end

    // payload shift register
    always_ff @(posedge clk) begin
        if (idle) begin
            if (ser_data_valid) begin
                cached_data <= ser_data;
            end
        end else if (ser_bit_req) begin
            if (bit_count != '0) begin
                cached_data <= {1'b0, cached_data[7:1]};
            end
        end else if (cache_data) begin
            // byte may arrive any time before the next bit request
            cached_data <= ser_data;
        end
    end

    assign ser_bit_valid = !idle;
    assign ser_bit       = cached_data[0];

endmodule

// File: bit_framer.sv
`timescale 1ns/1ps

module bit_framer (
    input  logic                      clk,
    input  logic                      rst_n,
    // serialiser side
    input  logic                      ser_bit,
    input  logic                      ser_bit_valid,
    input  iso_frame_pkg::bit_count_t src_bits,
    output logic                      ser_bit_req,
    // encoder side
    input  logic                      enc_bit_req,
    output logic                      enc_bit,
    output logic                      enc_active,
    // controller
    output logic                      frame_end
);

    import iso_frame_pkg::*;

    typedef enum logic [1:0] {
        FR_IDLE,
        FR_SEND,
        // inactive symbol presented, not yet latched
        FR_EOF,
        // encoder is running the unmodulated etu
        FR_EOF_ETU
    } fr_state_t;

    fr_state_t  state;
    bit_count_t bits_left;

    // all bits of the current byte presented, parity is next
    logic       byte_done;

    // odd parity, starts at 1 and toggles on every one
    logic       parity;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= FR_IDLE;
            bits_left   <= '0;
            byte_done   <= 1'b0;
            parity      <= 1'b1;
            enc_bit     <= 1'b0;
            enc_active  <= 1'b0;
            ser_bit_req <= 1'b0;
            frame_end   <= 1'b0;
        end else begin
            ser_bit_req <= 1'b0;
            frame_end   <= 1'b0;

            case (state)
                FR_IDLE: begin
                    if (ser_bit_valid) begin
                        // start of communication, logic 1
                        state      <= FR_SEND;
                        enc_active <= 1'b1;
                        enc_bit    <= 1'b1;
                        bits_left  <= src_bits;
                        byte_done  <= 1'b0;
                        parity     <= 1'b1;
                    end
                end
                FR_SEND: begin
                    // encoder took the last symbol, present the next one
                    if (enc_bit_req) begin
                        if (byte_done) begin
                            enc_bit   <= parity;
                            byte_done <= 1'b0;
                            bits_left <= 3'd7;
                            parity    <= 1'b1;
                        end else if (ser_bit_valid) begin
                            enc_bit     <= ser_bit;
                            ser_bit_req <= 1'b1;
                            parity      <= parity ^ ser_bit;
                            if (bits_left == '0) begin
                                byte_done <= 1'b1;
                            end else begin
                                bits_left <= bits_left - 1'b1;
                            end
                        end else begin
                            // data ended, one quiet etu closes the frame
                            state      <= FR_EOF;
                            enc_active <= 1'b0;
                            enc_bit    <= 1'b0;
                        end
                    end
                end
                FR_EOF: begin
                    if (enc_bit_req) begin
                        state <= FR_EOF_ETU;
                    end
                end
                FR_EOF_ETU: begin
                    if (enc_bit_req) begin
                        state     <= FR_IDLE;
                        frame_end <= 1'b1;
                    end
                end
                default: begin
                    state <= FR_IDLE;
                end
            endcase
        end
    end

endmodule

// File: subcarrier_encoder.sv
`timescale 1ns/1ps

module subcarrier_encoder (
    input  logic clk,
    input  logic rst_n,
    input  logic enc_bit,
    input  logic enc_active,
    output logic enc_bit_req,
    output logic lm_out
);

    import tx_signal_pkg::*;

    enc_phase_t phase;
    etu_count_t etu_count;

    // symbol for the running etu
    logic bit_q;
    logic active_q;

    logic etu_end;
    logic mod_half;
    logic sub_high;

    assign etu_end = (phase == ENC_BIT) && (etu_count == etu_count_t'(ETU_CYCLES - 1));

    // framer advances on the same cycle the symbol is latched
    assign enc_bit_req = ((phase == ENC_IDLE) && enc_active) || etu_end;

    // logic 1 loads the first half, logic 0 the second
    assign mod_half = bit_q ? (etu_count < HALF_ETU_CYCLES) : (etu_count >= HALF_ETU_CYCLES);

    // fc/16, high for the first 8 clocks of every 16
    assign sub_high = ((etu_count / SUBCARRIER_HALF) % 2) == 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase     <= ENC_IDLE;
            etu_count <= '0;
            bit_q     <= 1'b0;
            active_q  <= 1'b0;
            lm_out    <= 1'b0;
        end else begin
            case (phase)
                ENC_IDLE: begin
                    // counting starts with the first active cycle
                    if (enc_active) begin
                        phase     <= ENC_BIT;
                        etu_count <= '0;
                        bit_q     <= enc_bit;
                        active_q  <= 1'b1;
                    end
                end
                ENC_BIT: begin
                    if (etu_end) begin
                        etu_count <= '0;
                        bit_q     <= enc_bit;
                        active_q  <= enc_active;
                        // quiet etu just finished
                        if (!active_q) begin
                            phase <= ENC_IDLE;
                        end
                    end else begin
                        etu_count <= etu_count + 1'b1;
                    end
                end
                default: begin
                    phase <= ENC_IDLE;
                end
            endcase

            // registered so the modulator sees a clean level
            lm_out <= (phase == ENC_BIT) && active_q && mod_half && sub_high;
        end
    end

endmodule

// File: tx_controller.sv
`timescale 1ns/1ps

module tx_controller (
    input  logic                 clk,
    input  logic                 rst_n,
    // frame source
    input  iso_frame_pkg::byte_t src_data,
    input  logic                 src_valid,
    input  logic                 append_crc,
    output logic                 src_req,
    // serialiser side
    output iso_frame_pkg::byte_t ser_data,
    output logic                 ser_data_valid,
    input  logic                 ser_byte_req,
    // crc register
    output logic                 crc_init,
    output logic                 crc_byte_en,
    output iso_frame_pkg::byte_t crc_byte,
    input  iso_frame_pkg::crc_t  crc_value,
    // framer
    input  logic                 frame_end,
    // status
    output logic                 tx_busy,
    output logic                 tx_done
);

    import iso_frame_pkg::*;

    ctrl_state_t state;

    // append_crc captured at frame start
    logic crc_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= CTRL_IDLE;
            crc_en      <= 1'b0;
            src_req     <= 1'b0;
            crc_init    <= 1'b0;
            crc_byte_en <= 1'b0;
            tx_done     <= 1'b0;
        end else begin
            // strobes, one cycle each
            src_req     <= 1'b0;
            crc_init    <= 1'b0;
            crc_byte_en <= 1'b0;
            tx_done     <= 1'b0;

            case (state)
                CTRL_IDLE: begin
                    if (src_valid) begin
                        state    <= CTRL_DATA;
                        crc_en   <= append_crc;
                        crc_init <= 1'b1;
                    end
                end
                CTRL_DATA: begin
                    if (ser_byte_req) begin
                        // byte on src_data is taken, fold it in and ask for more
                        src_req     <= 1'b1;
                        crc_byte_en <= 1'b1;
                    end else if (!src_valid) begin
                        // source has nothing more
                        state <= crc_en ? CTRL_CRC_LO : CTRL_DRAIN;
                    end
                end
                CTRL_CRC_LO: begin
                    if (ser_byte_req) begin
                        state <= CTRL_CRC_HI;
                    end
                end
                CTRL_CRC_HI: begin
                    if (ser_byte_req) begin
                        state <= CTRL_DRAIN;
                    end
                end
                CTRL_DRAIN: begin
                    // last bits are still on air
                    if (frame_end) begin
                        state   <= CTRL_IDLE;
                        tx_done <= 1'b1;
                    end
                end
                default: begin
                    state <= CTRL_IDLE;
                end
            endcase
        end
    end

    // source still holds the consumed byte when the request is seen
    always_ff @(posedge clk) begin
        if ((state == CTRL_DATA) && ser_byte_req) begin
            crc_byte <= src_data;
        end
    end

    // byte mux into the serialiser
    always_comb begin
        ser_data       = src_data;
        ser_data_valid = 1'b0;
        case (state)
            CTRL_DATA: begin
                if (src_valid) begin
                    ser_data_valid = 1'b1;
                end else if (crc_en) begin
                    // keep valid up while the state moves on to the crc
                    ser_data       = crc_value[7:0];
                    ser_data_valid = 1'b1;
                end
            end
            CTRL_CRC_LO: begin
                ser_data       = crc_value[7:0];
                ser_data_valid = 1'b1;
            end
            CTRL_CRC_HI: begin
                ser_data       = crc_value[15:8];
                ser_data_valid = 1'b1;
            end
            default: begin
                ser_data_valid = 1'b0;
            end
        endcase
    end

    assign tx_busy = (state != CTRL_IDLE);

endmodule

// File: tx_top.sv
`timescale 1ns/1ps

module tx_top (
    input  logic                      clk,
    input  logic                      rst_n,
    // frame source
    input  iso_frame_pkg::byte_t      src_data,
    input  logic                      src_valid,
    input  iso_frame_pkg::bit_count_t src_bits,
    input  logic                      append_crc,
    output logic                      src_req,
    // status
    output logic                      tx_busy,
    output logic                      tx_done,
    // load modulation
    output logic                      lm_out
);

    import iso_frame_pkg::*;

    // controller to serialiser
    byte_t ser_data;
    logic  ser_data_valid;
    logic  ser_byte_req;

    // controller to crc
    logic  crc_init;
    logic  crc_byte_en;
    byte_t crc_byte;
    crc_t  crc_value;

    // serialiser to framer
    logic  ser_bit;
    logic  ser_bit_valid;
    logic  ser_bit_req;

    // framer to encoder
    logic  enc_bit;
    logic  enc_active;
    logic  enc_bit_req;
    logic  frame_end;

    tx_controller u_tx_controller (
        .clk            (clk),
        .rst_n          (rst_n),
        .src_data       (src_data),
        .src_valid      (src_valid),
        .append_crc     (append_crc),
        .src_req        (src_req),
        .ser_data       (ser_data),
        .ser_data_valid (ser_data_valid),
        .ser_byte_req   (ser_byte_req),
        .crc_init       (crc_init),
        .crc_byte_en    (crc_byte_en),
        .crc_byte       (crc_byte),
        .crc_value      (crc_value),
        .frame_end      (frame_end),
        .tx_busy        (tx_busy),
        .tx_done        (tx_done)
    );

    crc_a u_crc_a (
        .clk         (clk),
        .rst_n       (rst_n),
        .crc_init    (crc_init),
        .crc_byte_en (crc_byte_en),
        .crc_byte    (crc_byte),
        .crc_value   (crc_value)
    );

    serialiser u_serialiser (
        .clk            (clk),
        .rst_n          (rst_n),
        .ser_data       (ser_data),
        .ser_data_valid (ser_data_valid),
        .src_bits       (src_bits),
        .ser_byte_req   (ser_byte_req),
        .ser_bit_req    (ser_bit_req),
        .ser_bit        (ser_bit),
        .ser_bit_valid  (ser_bit_valid)
    );

    bit_framer u_bit_framer (
        .clk           (clk),
        .rst_n         (rst_n),
        .ser_bit       (ser_bit),
        .ser_bit_valid (ser_bit_valid),
        .src_bits      (src_bits),
        .ser_bit_req   (ser_bit_req),
        .enc_bit_req   (enc_bit_req),
        .enc_bit       (enc_bit),
        .enc_active    (enc_active),
        .frame_end     (frame_end)
    );

    subcarrier_encoder u_subcarrier_encoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .enc_bit     (enc_bit),
        .enc_active  (enc_active),
        .enc_bit_req (enc_bit_req),
        .lm_out      (lm_out)
    );

endmodule

// File: tx_checker.sv
`timescale 1ns/1ps

module tx_checker (
    input  logic                      clk,
    // dut outputs under watch
    input  logic                      lm_out,
    input  logic                      tx_busy,
    input  logic                      tx_done,
    input  logic                      src_req,
    // frame content, set by the source when the frame starts
    input  logic [47:0]               frame_bytes,
    input  int                        frame_len,
    input  iso_frame_pkg::bit_count_t frame_bits,
    input  logic                      frame_crc,
    // tallies for the closing report
    output int                        bit_errors,
    output int                        other_errors,
    output int                        frames_checked,
    output int                        done_pulses
);

    import iso_frame_pkg::*;
    import tx_signal_pkg::*;

    // longest frame is 73 symbols
    localparam int MAX_ETUS  = 100;
    localparam int SYM_ZERO  = 0;
    localparam int SYM_ONE   = 1;
    localparam int SYM_QUIET = 2;
    localparam int SYM_BAD   = 3;

    // set from the first rise until the end-of-frame etu is over
    logic in_frame = 1'b0;

    // ISO 14443-3 annex B byte update
    function automatic crc_t crc_a_update(input crc_t crc, input byte_t data);
        byte_t ch;
        ch = data ^ crc[7:0];
        ch = ch ^ (ch << 4);
        crc_a_update = (crc >> 8) ^ ({8'h00, ch} << 8) ^ ({8'h00, ch} << 3)
                       ^ ({8'h00, ch} >> 4);
    endfunction

    // symbol i of the frame at bit i
    function automatic logic [127:0] expected_bits(input logic [47:0] bytes, input int len,
                                                   input bit_count_t first_bits,
                                                   input logic with_crc);
        logic [127:0] s;
        crc_t         crc;
        byte_t        b;
        logic         par;
        int           pos;
        int           nbits;
        int           k;
        int           i;
        s   = '0;
        crc = 16'h6363;
        // start of communication
        s[0] = 1'b1;
        pos  = 1;
        for (k = 0; k < len + (with_crc ? 2 : 0); k++) begin
            if (k < len) begin
                b = bytes[8*k +: 8];
            end else if (k == len) begin
                b = crc[7:0];
            end else begin
                b = crc[15:8];
            end
            nbits = (k == 0) ? int'(first_bits) + 1 : 8;
            par   = 1'b1;
            // lsb first, odd parity over the bits actually sent
            for (i = 0; i < nbits; i++) begin
                s[pos] = b[i];
                par    = par ^ b[i];
                pos++;
            end
            s[pos] = par;
            pos++;
            if (k < len) begin
                crc = crc_a_update(crc, b);
            end
        end
        expected_bits = s;
    endfunction

    // start bit, first byte and parity, full bytes, crc bytes
    function automatic int expected_length(input int len, input bit_count_t first_bits,
                                           input logic with_crc);
        expected_length = 1 + int'(first_bits) + 2 + (len - 1) * 9 + (with_crc ? 18 : 0);
    endfunction

    // ideal lm_out over one etu for a data symbol
    function automatic logic [127:0] subcarrier_wave(input logic b);
        logic [127:0] w;
        logic         in_half;
        int           i;
        w = '0;
        for (i = 0; i < ETU_CYCLES; i++) begin
            in_half = b ? (i < HALF_ETU_CYCLES) : (i >= HALF_ETU_CYCLES);
            w[i]    = in_half && ((i % (2 * SUBCARRIER_HALF)) < SUBCARRIER_HALF);
        end
        subcarrier_wave = w;
    endfunction

    // one etu on the fixed grid, from the current sample to its last one
    task automatic capture_etu(input int etu_idx, output int sym);
        logic [127:0] wave;
        logic         busy_lost;
        int           i;
        busy_lost = 1'b0;
        for (i = 0; i < ETU_CYCLES; i++) begin
            wave[i] = lm_out;
            if (tx_busy !== 1'b1) begin
                busy_lost = 1'b1;
            end
            // stays on the last sample of the etu
            if (i < ETU_CYCLES - 1) begin
                @(negedge clk);
            end
        end
        if (busy_lost) begin
            other_errors = other_errors + 1;
            $display("error at %0t: tx_busy went low during etu %0d of frame %0d",
                     $time, etu_idx, frames_checked);
        end
        if (wave === '0) begin
            sym = SYM_QUIET;
        end else if (wave === subcarrier_wave(1'b1)) begin
            sym = SYM_ONE;
        end else if (wave === subcarrier_wave(1'b0)) begin
            sym = SYM_ZERO;
        end else begin
            sym = SYM_BAD;
        end
    endtask

    task automatic check_frame();
        logic [127:0] exp_stream;
        logic [127:0] got;
        logic         seen_done;
        int           exp_len;
        int           n;
        int           sym;
        int           pos;
        int           gsize;
        int           ones;
        int           byte_idx;
        int           i;
        exp_stream = expected_bits(frame_bytes, frame_len, frame_bits, frame_crc);
        exp_len    = expected_length(frame_len, frame_bits, frame_crc);
        in_frame   = 1'b1;
        got        = '0;
        n          = 0;
        capture_etu(n, sym);
        while (sym != SYM_QUIET && n < MAX_ETUS) begin
            if (sym == SYM_BAD) begin
                got[n] = 1'bx;
                other_errors = other_errors + 1;
                $display("error at %0t: etu %0d of frame %0d is not a clean subcarrier symbol",
                         $time, n, frames_checked);
            end else begin
                got[n] = (sym == SYM_ONE);
            end
            if (n < exp_len && got[n] !== exp_stream[n]) begin
                bit_errors = bit_errors + 1;
                $display("error at %0t: lm_out bit %0d of frame %0d expected %b got %b",
                         $time, n, frames_checked, exp_stream[n], got[n]);
            end
            n++;
            // next etu starts one clock on
            @(negedge clk);
            capture_etu(n, sym);
        end
        in_frame = 1'b0;
        if (sym != SYM_QUIET) begin
            other_errors = other_errors + 1;
            $display("error at %0t: frame %0d never reached an unmodulated etu",
                     $time, frames_checked);
        end
        if (n != exp_len) begin
            other_errors = other_errors + 1;
            $display("error at %0t: frame %0d decoded to %0d bits, %0d were due",
                     $time, frames_checked, n, exp_len);
        end
        // odd parity per byte, first group may be short
        pos      = 1;
        gsize    = int'(frame_bits) + 1;
        byte_idx = 0;
        while (pos + gsize < n) begin
            ones = 0;
            for (i = 0; i <= gsize; i++) begin
                if (got[pos + i] === 1'b1) begin
                    ones++;
                end
            end
            if (ones % 2 == 0) begin
                other_errors = other_errors + 1;
                $display("error at %0t: parity of byte %0d in frame %0d is even",
                         $time, byte_idx, frames_checked);
            end
            pos = pos + gsize + 1;
            gsize = 8;
            byte_idx++;
        end
        // completion follows the quiet etu within a few clocks
        seen_done = 1'b0;
        for (i = 0; i < 16 && !seen_done; i++) begin
            if (tx_done === 1'b1) begin
                seen_done = 1'b1;
            end else begin
                @(negedge clk);
            end
        end
        if (!seen_done) begin
            other_errors = other_errors + 1;
            $display("error at %0t: no tx_done after frame %0d", $time, frames_checked);
        end
        frames_checked = frames_checked + 1;
    endtask

    // sampled at negedge, away from the dut's clock edge
    initial begin
        bit_errors     = 0;
        other_errors   = 0;
        frames_checked = 0;
        done_pulses    = 0;
        forever begin
            @(negedge clk);
            if (lm_out === 1'b1) begin
                check_frame();
            end
        end
    end

    always @(negedge clk) begin
        if (tx_done === 1'b1) begin
            done_pulses = done_pulses + 1;
            if (in_frame) begin
                other_errors = other_errors + 1;
                $display("error at %0t: tx_done pulsed before the end-of-frame etu", $time);
            end
        end
        if (src_req === 1'b1 && tx_busy !== 1'b1) begin
            other_errors = other_errors + 1;
            $display("error at %0t: src_req pulsed while tx_busy was low", $time);
        end
    end

endmodule

// File: tb_tx_top.sv
`timescale 1ns/1ps

module tb_tx_top;

    import iso_frame_pkg::*;

    localparam int FRAME_COUNT = 14;
    // 14 frames of at most 110 etus of 128 clocks, rounded up
    localparam int TIMEOUT_CYCLES = 200000;

    logic       clk = 1'b0;
    logic       rst_n;
    byte_t      src_data;
    logic       src_valid;
    bit_count_t src_bits;
    logic       append_crc;
    logic       src_req;
    logic       tx_busy;
    logic       tx_done;
    logic       lm_out;

    // frame currently on air, for the checker
    logic [47:0] frame_bytes;
    int          frame_len;
    bit_count_t  frame_bits;
    logic        frame_crc;

    int     bit_errors;
    int     other_errors;
    int     frames_checked;
    int     done_pulses;
    int     tb_errors;
    int     total_errors;
    int     cycle_count = 0;
    integer seed;

    always #5 clk = ~clk;

    tx_top uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .src_data   (src_data),
        .src_valid  (src_valid),
        .src_bits   (src_bits),
        .append_crc (append_crc),
        .src_req    (src_req),
        .tx_busy    (tx_busy),
        .tx_done    (tx_done),
        .lm_out     (lm_out)
    );

    tx_checker u_checker (
        .clk            (clk),
        .lm_out         (lm_out),
        .tx_busy        (tx_busy),
        .tx_done        (tx_done),
        .src_req        (src_req),
        .frame_bytes    (frame_bytes),
        .frame_len      (frame_len),
        .frame_bits     (frame_bits),
        .frame_crc      (frame_crc),
        .bit_errors     (bit_errors),
        .other_errors   (other_errors),
        .frames_checked (frames_checked),
        .done_pulses    (done_pulses)
    );

    function automatic int random_range(input int lo, input int hi);
        random_range = lo + ({$random(seed)} % (hi - lo + 1));
    endfunction

    // src_req is a registered pulse, seen here one edge late
    task automatic wait_src_req();
        do @(posedge clk); while (src_req !== 1'b1);
    endtask

    // source model, one frame from first byte to tx_done
    task automatic run_frame(input int len, input bit_count_t first_bits, input logic with_crc);
        logic [47:0] bytes;
        logic [31:0] rnd;
        int          k;
        bytes = '0;
        for (k = 0; k < len; k++) begin
            rnd = $random(seed);
            bytes[8*k +: 8] = rnd[7:0];
        end
        @(posedge clk);
        frame_bytes <= bytes;
        frame_len   <= len;
        frame_bits  <= first_bits;
        frame_crc   <= with_crc;
        src_data    <= bytes[7:0];
        src_bits    <= first_bits;
        append_crc  <= with_crc;
        src_valid   <= 1'b1;
        for (k = 1; k <= len; k++) begin
            wait_src_req();
            // slow source, well inside the 100 cycle rule
            repeat (random_range(1, 20) - 1) @(posedge clk);
            if (k < len) begin
                src_data <= bytes[8*k +: 8];
            end else begin
                src_valid <= 1'b0;
            end
        end
        do @(posedge clk); while (tx_done !== 1'b1);
        repeat (random_range(2, 10)) @(posedge clk);
    endtask

    initial begin
        int f;
        int len;
        int with_crc;
        seed      = 88;
        tb_errors = 0;
        rst_n       <= 1'b0;
        src_data    <= '0;
        src_valid   <= 1'b0;
        src_bits    <= 3'd7;
        append_crc  <= 1'b0;
        frame_bytes <= '0;
        frame_len   <= 0;
        frame_bits  <= 3'd7;
        frame_crc   <= 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);
        for (f = 0; f < 12; f++) begin
            len      = random_range(1, 6);
            with_crc = random_range(0, 1);
            run_frame(len, 3'd7, with_crc[0]);
        end
        // bit oriented anticollision frames
        len = random_range(1, 6);
        run_frame(len, 3'd3, 1'b0);
        len = random_range(1, 6);
        run_frame(len, 3'd6, 1'b0);
        repeat (20) @(posedge clk);
        if (frames_checked != FRAME_COUNT) begin
            tb_errors++;
            $display("checker decoded %0d frames, %0d were sent", frames_checked, FRAME_COUNT);
        end
        if (done_pulses != FRAME_COUNT) begin
            tb_errors++;
            $display("tx_done was high on %0d cycles for %0d frames", done_pulses, FRAME_COUNT);
        end
        total_errors = bit_errors + other_errors + tb_errors;
        $display("frames %0d, lm_out bit errors %0d, other errors %0d, testbench errors %0d",
                 frames_checked, bit_errors, other_errors, tb_errors);
        if (total_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

endmodule

// File: compile.f
iso_frame_pkg.sv
tx_signal_pkg.sv
crc_a.sv
serialiser.sv
bit_framer.sv
subcarrier_encoder.sv
tx_controller.sv
tx_top.sv
tx_checker.sv
tb_tx_top.sv
